// File: dwc_upsizer.f
source/dwc_pkg.sv
source/dwc_burst_if.sv
source/dwc_burst_decoder.sv
source/dwc_write_packer.sv
source/dwc_read_unpacker.sv
source/dwc_upsizer.sv
sim/dwc_wide_mem_model.sv
sim/tb_dwc_upsizer.sv

// File: run_sim.sh
#!/bin/sh
# Builds the upsizer testbench with Verilator and runs it

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_dwc_upsizer \
  --Mdir "$BUILD_DIR" \
  -f dwc_upsizer.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_dwc_upsizer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: sim/tb_dwc_upsizer.sv
`timescale 1ns/100ps

module tb_dwc_upsizer;
  import dwc_pkg::*;

  localparam int TIMEOUT_CYCLES = 1000;

  logic                         clk;
  logic                         arst_n;
  logic                         s_aw_valid, s_aw_ready, s_ar_valid, s_ar_ready;
  logic [ID_WIDTH-1:0]          s_aw_id, s_ar_id, s_b_id, s_r_id;
  logic [ADDR_WIDTH-1:0]        s_aw_addr, s_ar_addr;
  logic [LEN_WIDTH-1:0]         s_aw_len, s_ar_len;
  logic                         s_w_valid, s_w_ready, s_w_last;
  logic [NARROW_DATA_WIDTH-1:0] s_w_data, s_r_data;
  logic [NARROW_STRB_WIDTH-1:0] s_w_strb;
  logic                         s_b_valid, s_b_ready, s_r_valid, s_r_ready, s_r_last;
  logic [RESP_WIDTH-1:0]        s_b_resp, s_r_resp, m_b_resp, m_r_resp;
  logic                         m_aw_valid, m_aw_ready, m_ar_valid, m_ar_ready;
  logic [ID_WIDTH-1:0]          m_aw_id, m_ar_id, m_b_id, m_r_id;
  logic [ADDR_WIDTH-1:0]        m_aw_addr, m_ar_addr;
  logic [LEN_WIDTH-1:0]         m_aw_len, m_ar_len;
  logic                         m_w_valid, m_w_ready, m_w_last;
  logic [WIDE_DATA_WIDTH-1:0]   m_w_data, m_r_data;
  logic [WIDE_STRB_WIDTH-1:0]   m_w_strb;
  logic                         m_b_valid, m_b_ready, m_r_valid, m_r_ready, m_r_last;
  logic                         backpressure;
  logic [2:0]                   ready_noise;
  integer                       seed = 32'h42b;
  // Expected narrow words indexed by byte address bits 10 to 2
  logic [NARROW_DATA_WIDTH-1:0] ref_mem [0:511];
  logic [NARROW_DATA_WIDTH-1:0] wr_data [0:255];

  dwc_upsizer i_dut (.*);
  dwc_wide_mem_model i_mem (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(negedge clk) begin
    ready_noise = 3'($random(seed));
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("error %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic send_ar(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                         input logic [LEN_WIDTH-1:0] len);
    int cycles;
    s_ar_valid = 1'b1;
    s_ar_id    = id;
    s_ar_addr  = addr;
    s_ar_len   = len;
    cycles     = 0;
    while (!s_ar_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timeout while waiting for the read address ready");
    end
    @(negedge clk);
    s_ar_valid = 1'b0;
  endtask

  // Collects len+1 beats with s_r_ready held high or random
  task automatic collect_r(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [LEN_WIDTH-1:0] len, input logic random_ready);
    int          cycles;
    int          k;
    logic [8:0]  idx;
    logic [31:0] rnd;
    idx    = addr[10:2];
    k      = 0;
    cycles = 0;
    while (k <= int'(len)) begin
      rnd       = $random(seed);
      s_r_ready = !random_ready || rnd[0];
      if (s_r_valid && s_r_ready) begin
        check_value("s_r_data", s_r_data, ref_mem[idx]);
        check_value("s_r_id", 32'(s_r_id), 32'(id));
        check_value("s_r_resp", 32'(s_r_resp), 32'h0);
        check_value("s_r_last", 32'(s_r_last), 32'(k == int'(len)));
        idx++;
        k++;
        cycles = 0;
      end
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timeout while waiting for read data");
    end
    s_r_ready = 1'b0;
  endtask

  task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [LEN_WIDTH-1:0] len, input logic random_ready);
    send_ar(id, addr, len);
    collect_r(id, addr, len, random_ready);
  endtask

  // Sends wr_data[0..len] and waits for the write response
  task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [LEN_WIDTH-1:0] len);
    int         cycles;
    logic [8:0] idx;
    idx        = addr[10:2];
    s_aw_valid = 1'b1;
    s_aw_id    = id;
    s_aw_addr  = addr;
    s_aw_len   = len;
    cycles     = 0;
    while (!s_aw_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timeout while waiting for the write address ready");
    end
    @(negedge clk);
    s_aw_valid = 1'b0;
    // Wide beats touched, counted from the first and last narrow byte address
    check_value("m_aw_len", 32'(m_aw_len),
                ((addr + 32'(len) * 4) >> 5) - (addr >> 5));
    for (int k = 0; k <= int'(len); k++) begin
      s_w_valid = 1'b1;
      s_w_data  = wr_data[k];
      s_w_last  = (k == int'(len));
      cycles    = 0;
      while (!s_w_ready) begin
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT_CYCLES) fail_run("timeout while waiting for write data ready");
      end
      ref_mem[idx] = wr_data[k];
      idx++;
      @(negedge clk);
    end
    s_w_valid = 1'b0;
    s_w_last  = 1'b0;
    s_b_ready = 1'b1;
    cycles    = 0;
    while (!s_b_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timeout while waiting for the write response");
    end
    check_value("s_b_id", 32'(s_b_id), 32'(id));
    check_value("s_b_resp", 32'(s_b_resp), 32'h0);
    @(negedge clk);
    s_b_ready = 1'b0;
  endtask

  task automatic aligned_single_beat();
    wr_data[0] = 32'hCAFE0100;
    write_burst(4'd3, 32'h100, 8'd0);
    read_burst(4'd3, 32'h100, 8'd0, 1'b0);
  endtask

  // Lanes 5 to 7 and then 0 to 2 of the next wide beat
  task automatic unaligned_burst();
    for (int k = 0; k < 16; k++) begin
      wr_data[k] = 32'h10000000 + 32'(k);
    end
    write_burst(4'd5, 32'h200, 8'd15);
    for (int k = 0; k < 6; k++) begin
      wr_data[k] = $random(seed);
    end
    write_burst(4'd6, 32'h214, 8'd5);
    read_burst(4'd7, 32'h200, 8'd15, 1'b0);
  endtask

  task automatic long_burst_backpressure();
    backpressure = 1'b1;
    for (int k = 0; k < 21; k++) begin
      wr_data[k] = $random(seed);
    end
    write_burst(4'd8, 32'h308, 8'd20);
    read_burst(4'd9, 32'h308, 8'd20, 1'b0);
    backpressure = 1'b0;
  endtask

  task automatic narrow_read_backpressure();
    read_burst(4'd10, 32'h404, 8'd12, 1'b1);
  endtask

  // Second request is taken while the first burst is still held
  task automatic overlapping_reads();
    send_ar(4'd1, 32'h200, 8'd3);
    send_ar(4'd2, 32'h308, 8'd6);
    collect_r(4'd1, 32'h200, 8'd3, 1'b0);
    collect_r(4'd2, 32'h308, 8'd6, 1'b0);
  endtask

  initial begin
    arst_n       = 1'b0;
    backpressure = 1'b0;
    ready_noise  = '0;
    s_aw_valid   = 1'b0;
    s_aw_id      = '0;
    s_aw_addr    = '0;
    s_aw_len     = '0;
    s_w_valid    = 1'b0;
    s_w_data     = '0;
    s_w_strb     = '1;
    s_w_last     = 1'b0;
    s_b_ready    = 1'b0;
    s_ar_valid   = 1'b0;
    s_ar_id      = '0;
    s_ar_addr    = '0;
    s_ar_len     = '0;
    s_r_ready    = 1'b0;
    for (int a = 0; a < 512; a++) begin
      ref_mem[a] = 32'h5A5A0000 ^ 32'(a * 4);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    aligned_single_beat();
    unaligned_burst();
    long_burst_backpressure();
    narrow_read_backpressure();
    overlapping_reads();
    $display("Regression passed");
    $finish;
  end

endmodule

// File: sim/dwc_wide_mem_model.sv
`timescale 1ns/100ps

module dwc_wide_mem_model (
  input  logic                                clk,
  input  logic                                arst_n,
  // Random ready stalls when set with one noise bit per address or data channel
  input  logic                                backpressure,
  input  logic [2:0]                          ready_noise,
  input  logic                                m_aw_valid,
  output logic                                m_aw_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]        m_aw_id,
  input  logic [dwc_pkg::ADDR_WIDTH-1:0]      m_aw_addr,
  input  logic                                m_w_valid,
  output logic                                m_w_ready,
  input  logic [dwc_pkg::WIDE_DATA_WIDTH-1:0] m_w_data,
  input  logic [dwc_pkg::WIDE_STRB_WIDTH-1:0] m_w_strb,
  input  logic                                m_w_last,
  output logic                                m_b_valid,
  input  logic                                m_b_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]        m_b_id,
  output logic [dwc_pkg::RESP_WIDTH-1:0]      m_b_resp,
  input  logic                                m_ar_valid,
  output logic                                m_ar_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]        m_ar_id,
  input  logic [dwc_pkg::ADDR_WIDTH-1:0]      m_ar_addr,
  input  logic [dwc_pkg::LEN_WIDTH-1:0]       m_ar_len,
  output logic                                m_r_valid,
  input  logic                                m_r_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]        m_r_id,
  output logic [dwc_pkg::WIDE_DATA_WIDTH-1:0] m_r_data,
  output logic [dwc_pkg::RESP_WIDTH-1:0]      m_r_resp,
  output logic                                m_r_last
);
  import dwc_pkg::*;

  localparam int DEPTH = 64;

  logic [WIDE_DATA_WIDTH-1:0] mem [0:DEPTH-1];
  logic                       wr_active;
  logic                       rd_active;
  logic [5:0]                 wr_idx;
  logic [5:0]                 rd_idx;
  logic [LEN_WIDTH-1:0]       rd_cnt;
  logic                       aw_ok;
  logic                       w_ok;
  logic                       ar_ok;

  assign aw_ok = !backpressure || ready_noise[0];
  assign w_ok  = !backpressure || ready_noise[1];
  assign ar_ok = !backpressure || ready_noise[2];

  // One burst per direction at a time and answered in order
  assign m_aw_ready = !wr_active && !m_b_valid && aw_ok;
  assign m_w_ready  = wr_active && w_ok;
  assign m_ar_ready = !rd_active && ar_ok;
  assign m_b_resp   = '0;
  assign m_r_valid  = rd_active;
  assign m_r_data   = mem[rd_idx];
  assign m_r_resp   = '0;
  assign m_r_last   = (rd_cnt == '0);

  // Each narrow word starts as a pattern of its own byte address
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      for (int j = 0; j < LANE_COUNT; j++) begin
        mem[i][j*NARROW_DATA_WIDTH +: NARROW_DATA_WIDTH] = 32'h5A5A0000 ^ 32'(i * 32 + j * 4);
      end
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_active <= 1'b0;
      rd_active <= 1'b0;
      m_b_valid <= 1'b0;
      m_b_id    <= '0;
      m_r_id    <= '0;
      wr_idx    <= '0;
      rd_idx    <= '0;
      rd_cnt    <= '0;
    end else begin
      if (m_aw_valid && m_aw_ready) begin
        wr_active <= 1'b1;
        wr_idx    <= m_aw_addr[10:5];
        m_b_id    <= m_aw_id;
      end
      if (m_w_valid && m_w_ready) begin
        wr_idx <= wr_idx + 1'b1;
        if (m_w_last) begin
          wr_active <= 1'b0;
          m_b_valid <= 1'b1;
        end
      end
      if (m_b_valid && m_b_ready) begin
        m_b_valid <= 1'b0;
      end
      if (m_ar_valid && m_ar_ready) begin
        rd_active <= 1'b1;
        rd_idx    <= m_ar_addr[10:5];
        rd_cnt    <= m_ar_len;
        m_r_id    <= m_ar_id;
      end
      if (m_r_valid && m_r_ready) begin
        rd_idx <= rd_idx + 1'b1;
        rd_cnt <= rd_cnt - 1'b1;
        if (m_r_last) begin
          rd_active <= 1'b0;
        end
      end
    end
  end

  // Byte strobe write
  always @(posedge clk) begin
    if (m_w_valid && m_w_ready) begin
      for (int b = 0; b < WIDE_STRB_WIDTH; b++) begin
        if (m_w_strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= m_w_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// File: source/dwc_upsizer.sv
`timescale 1ns/100ps

module dwc_upsizer (
  input  logic                                  clk,
  input  logic                                  arst_n,
  // Narrow AW
  input  logic                                  s_aw_valid,
  output logic                                  s_aw_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]          s_aw_id,
  input  logic [dwc_pkg::ADDR_WIDTH-1:0]        s_aw_addr,
  input  logic [dwc_pkg::LEN_WIDTH-1:0]         s_aw_len,
  // Narrow W
  input  logic                                  s_w_valid,
  output logic                                  s_w_ready,
  input  logic [dwc_pkg::NARROW_DATA_WIDTH-1:0] s_w_data,
  input  logic [dwc_pkg::NARROW_STRB_WIDTH-1:0] s_w_strb,
  input  logic                                  s_w_last,
  // Narrow B
  output logic                                  s_b_valid,
  input  logic                                  s_b_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]          s_b_id,
  output logic [dwc_pkg::RESP_WIDTH-1:0]        s_b_resp,
  // Narrow AR
  input  logic                                  s_ar_valid,
  output logic                                  s_ar_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]          s_ar_id,
  input  logic [dwc_pkg::ADDR_WIDTH-1:0]        s_ar_addr,
  input  logic [dwc_pkg::LEN_WIDTH-1:0]         s_ar_len,
  // Narrow R
  output logic                                  s_r_valid,
  input  logic                                  s_r_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]          s_r_id,
  output logic [dwc_pkg::NARROW_DATA_WIDTH-1:0] s_r_data,
  output logic [dwc_pkg::RESP_WIDTH-1:0]        s_r_resp,
  output logic                                  s_r_last,
  // Wide AW
  output logic                                  m_aw_valid,
  input  logic                                  m_aw_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]          m_aw_id,
  output logic [dwc_pkg::ADDR_WIDTH-1:0]        m_aw_addr,
  output logic [dwc_pkg::LEN_WIDTH-1:0]         m_aw_len,
  // Wide W
  output logic                                  m_w_valid,
  input  logic                                  m_w_ready,
  output logic [dwc_pkg::WIDE_DATA_WIDTH-1:0]   m_w_data,
  output logic [dwc_pkg::WIDE_STRB_WIDTH-1:0]   m_w_strb,
  output logic                                  m_w_last,
  // Wide B
  input  logic                                  m_b_valid,
  output logic                                  m_b_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]          m_b_id,
  input  logic [dwc_pkg::RESP_WIDTH-1:0]        m_b_resp,
  // Wide AR
  output logic                                  m_ar_valid,
  input  logic                                  m_ar_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]          m_ar_id,
  output logic [dwc_pkg::ADDR_WIDTH-1:0]        m_ar_addr,
  output logic [dwc_pkg::LEN_WIDTH-1:0]         m_ar_len,
  // Wide R
  input  logic                                  m_r_valid,
  output logic                                  m_r_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]          m_r_id,
  input  logic [dwc_pkg::WIDE_DATA_WIDTH-1:0]   m_r_data,
  input  logic [dwc_pkg::RESP_WIDTH-1:0]        m_r_resp,
  input  logic                                  m_r_last
);

  dwc_burst_if aw_burst ();
  dwc_burst_if ar_burst ();

  // One wide burst per narrow burst, so B needs no merging
  assign s_b_valid = m_b_valid;
  assign m_b_ready = s_b_ready;
  assign s_b_id    = m_b_id;
  assign s_b_resp  = m_b_resp;

  dwc_burst_decoder i_aw_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .ax_valid   (s_aw_valid),
    .ax_ready   (s_aw_ready),
    .ax_id      (s_aw_id),
    .ax_addr    (s_aw_addr),
    .ax_len     (s_aw_len),
    .wide_valid (m_aw_valid),
    .wide_ready (m_aw_ready),
    .wide_id    (m_aw_id),
    .wide_addr  (m_aw_addr),
    .wide_len   (m_aw_len),
    .burst      (aw_burst.producer)
  );

  dwc_burst_decoder i_ar_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .ax_valid   (s_ar_valid),
    .ax_ready   (s_ar_ready),
    .ax_id      (s_ar_id),
    .ax_addr    (s_ar_addr),
    .ax_len     (s_ar_len),
    .wide_valid (m_ar_valid),
    .wide_ready (m_ar_ready),
    .wide_id    (m_ar_id),
    .wide_addr  (m_ar_addr),
    .wide_len   (m_ar_len),
    .burst      (ar_burst.producer)
  );

  dwc_write_packer i_write_packer (
    .clk        (clk),
    .arst_n     (arst_n),
    .w_valid    (s_w_valid),
    .w_ready    (s_w_ready),
    .w_data     (s_w_data),
    .w_strb     (s_w_strb),
    .w_last     (s_w_last),
    .wide_valid (m_w_valid),
    .wide_ready (m_w_ready),
    .wide_data  (m_w_data),
    .wide_strb  (m_w_strb),
    .wide_last  (m_w_last),
    .burst      (aw_burst.consumer)
  );

  dwc_read_unpacker i_read_unpacker (
    .clk        (clk),
    .arst_n     (arst_n),
    .wide_valid (m_r_valid),
    .wide_ready (m_r_ready),
    .wide_id    (m_r_id),
    .wide_data  (m_r_data),
    .wide_resp  (m_r_resp),
    .wide_last  (m_r_last),
    .r_valid    (s_r_valid),
    .r_ready    (s_r_ready),
    .r_id       (s_r_id),
    .r_data     (s_r_data),
    .r_resp     (s_r_resp),
    .r_last     (s_r_last),
    .burst      (ar_burst.consumer)
  );

endmodule

// File: source/dwc_read_unpacker.sv
`timescale 1ns/100ps

module dwc_read_unpacker (
  input  logic                                  clk,
  input  logic                                  arst_n,
  // Wide R
  input  logic                                  wide_valid,
  output logic                                  wide_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]          wide_id,
  input  logic [dwc_pkg::WIDE_DATA_WIDTH-1:0]   wide_data,
  input  logic [dwc_pkg::RESP_WIDTH-1:0]        wide_resp,
  input  logic                                  wide_last,
  // Narrow R
  output logic                                  r_valid,
  input  logic                                  r_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]          r_id,
  output logic [dwc_pkg::NARROW_DATA_WIDTH-1:0] r_data,
  output logic [dwc_pkg::RESP_WIDTH-1:0]        r_resp,
  output logic                                  r_last,
  // Read burst descriptor
  dwc_burst_if.consumer                         burst
);
  import dwc_pkg::*;

  unpack_state_e              state;
  logic                       desc_held;
  logic [LANE_WIDTH-1:0]      lane_cnt;
  logic [LEN_WIDTH-1:0]       remaining;
  logic [LEN_WIDTH-1:0]       wide_beat_cnt;
  logic [LEN_WIDTH-1:0]       final_wide;
  logic [LEN_WIDTH:0]         desc_wide_len;
  logic [WIDE_DATA_WIDTH-1:0] data_q;
  logic                       wide_fire;
  logic                       r_fire;
  logic                       lane_end;

  assign wide_ready  = (state == UNPACK_EMPTY) && desc_held;
  assign burst.ready = !desc_held;

  assign wide_fire = wide_valid && wide_ready;
  assign r_fire    = r_valid && r_ready;
  assign lane_end  = (lane_cnt == LANE_WIDTH'(LANE_COUNT - 1));

  // Index of the last wide beat of the burst
  assign desc_wide_len = ({1'b0, burst.len}
                         + {{(LEN_WIDTH + 1 - LANE_WIDTH){1'b0}}, burst.first_lane}) >> LANE_WIDTH;

  assign r_valid = (state == UNPACK_DRAIN);
  assign r_data  = data_q[lane_cnt*NARROW_DATA_WIDTH +: NARROW_DATA_WIDTH];
  assign r_last  = (remaining == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= UNPACK_EMPTY;
      desc_held     <= 1'b0;
      lane_cnt      <= '0;
      remaining     <= '0;
      wide_beat_cnt <= '0;
      final_wide    <= '0;
    end else begin
      if (burst.valid && burst.ready) begin
        desc_held     <= 1'b1;
        lane_cnt      <= burst.first_lane;
        remaining     <= burst.len;
        wide_beat_cnt <= '0;
        final_wide    <= desc_wide_len[LEN_WIDTH-1:0];
      end

      if (wide_fire) begin
        state         <= UNPACK_DRAIN;
        wide_beat_cnt <= wide_beat_cnt + 1'b1;
      end

      if (r_fire) begin
        lane_cnt  <= lane_cnt + 1'b1;
        remaining <= remaining - 1'b1;
        // Fetch the next wide beat after the top lane or the burst end
        if (lane_end || r_last) begin
          state <= UNPACK_EMPTY;
        end
        if (r_last) begin
          desc_held <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wide_fire) begin
      data_q <= wide_data;
      r_id   <= wide_id;
      r_resp <= wide_resp;
    end
  end

  // Slave ends the wide burst on the beat computed by the decoder
  a_wide_last: assert property (@(posedge clk) disable iff (!arst_n)
    wide_fire |-> (wide_last == (wide_beat_cnt == final_wide)));

endmodule

// File: source/dwc_write_packer.sv
`timescale 1ns/100ps

module dwc_write_packer (
  input  logic                                  clk,
  input  logic                                  arst_n,
  // Narrow W
  input  logic                                  w_valid,
  output logic                                  w_ready,
  input  logic [dwc_pkg::NARROW_DATA_WIDTH-1:0] w_data,
  input  logic [dwc_pkg::NARROW_STRB_WIDTH-1:0] w_strb,
  input  logic                                  w_last,
  // Wide W
  output logic                                  wide_valid,
  input  logic                                  wide_ready,
  output logic [dwc_pkg::WIDE_DATA_WIDTH-1:0]   wide_data,
  output logic [dwc_pkg::WIDE_STRB_WIDTH-1:0]   wide_strb,
  output logic                                  wide_last,
  // Write burst descriptor
  dwc_burst_if.consumer                         burst
);
  import dwc_pkg::*;

  logic                  desc_held;
  logic [LANE_WIDTH-1:0] lane_cnt;
  logic [LEN_WIDTH-1:0]  beat_cnt;
  logic [LEN_WIDTH-1:0]  len_q;
  logic                  w_fire;
  logic                  wide_fire;
  logic                  flush;

  // Narrow beats wait for a descriptor and for the wide beat to drain
  assign w_ready     = desc_held && !wide_valid;
  assign burst.ready = !desc_held;

  assign w_fire    = w_valid && w_ready;
  assign wide_fire = wide_valid && wide_ready;

  // Send the wide beat when its top lane fills or the burst ends
  assign flush = (lane_cnt == LANE_WIDTH'(LANE_COUNT - 1)) || w_last;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      desc_held  <= 1'b0;
      lane_cnt   <= '0;
      beat_cnt   <= '0;
      len_q      <= '0;
      wide_valid <= 1'b0;
      wide_strb  <= '0;
    end else begin
      if (burst.valid && burst.ready) begin
        desc_held <= 1'b1;
        lane_cnt  <= burst.first_lane;
        beat_cnt  <= '0;
        len_q     <= burst.len;
      end

      if (w_fire) begin
        wide_strb[lane_cnt*NARROW_STRB_WIDTH +: NARROW_STRB_WIDTH] <= w_strb;
        // Lane counter wraps to 0 at the next wide beat
        lane_cnt <= lane_cnt + 1'b1;
        beat_cnt <= beat_cnt + 1'b1;
        if (flush) begin
          wide_valid <= 1'b1;
        end
        if (w_last) begin
          desc_held <= 1'b0;
        end
      end

      // Lanes not written in the next beat must carry no strobes
      if (wide_fire) begin
        wide_valid <= 1'b0;
        wide_strb  <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (w_fire) begin
      wide_data[lane_cnt*NARROW_DATA_WIDTH +: NARROW_DATA_WIDTH] <= w_data;
      if (flush) begin
        wide_last <= w_last;
      end
    end
  end

  // Master marks the end of the burst exactly where the descriptor says
  a_wlast_on_len: assert property (@(posedge clk) disable iff (!arst_n)
    w_fire |-> (w_last == (beat_cnt == len_q)));

  a_wide_stable: assert property (@(posedge clk) disable iff (!arst_n)
    wide_valid && !wide_ready |=> wide_valid && $stable(wide_data)
                                  && $stable(wide_strb) && $stable(wide_last));

endmodule

// File: source/dwc_burst_decoder.sv
`timescale 1ns/100ps

module dwc_burst_decoder (
  input  logic                           clk,
  input  logic                           arst_n,
  // Narrow address request
  input  logic                           ax_valid,
  output logic                           ax_ready,
  input  logic [dwc_pkg::ID_WIDTH-1:0]   ax_id,
  input  logic [dwc_pkg::ADDR_WIDTH-1:0] ax_addr,
  input  logic [dwc_pkg::LEN_WIDTH-1:0]  ax_len,
  // Wide address request
  output logic                           wide_valid,
  input  logic                           wide_ready,
  output logic [dwc_pkg::ID_WIDTH-1:0]   wide_id,
  output logic [dwc_pkg::ADDR_WIDTH-1:0] wide_addr,
  output logic [dwc_pkg::LEN_WIDTH-1:0]  wide_len,
  // Descriptor towards packer or unpacker
  dwc_burst_if.producer                  burst
);
  import dwc_pkg::*;

  decoder_state_e        state;
  logic                  wide_sent;
  logic                  desc_sent;
  logic                  wide_done;
  logic                  desc_done;
  logic                  ax_fire;
  logic [LANE_WIDTH-1:0] ax_lane;
  logic [LANE_WIDTH-1:0] first_lane;
  logic [LEN_WIDTH-1:0]  narrow_len;
  logic [LEN_WIDTH:0]    wide_len_full;

  assign ax_fire = ax_valid && ax_ready;
  assign ax_lane = ax_addr[LANE_LSB +: LANE_WIDTH];

  // Wide beats minus one as (first lane + narrow len) / lanes per beat
  assign wide_len_full = ({1'b0, ax_len}
                         + {{(LEN_WIDTH + 1 - LANE_WIDTH){1'b0}}, ax_lane}) >> LANE_WIDTH;

  // Both sides of the burst are offered together and each drops once taken
  assign wide_valid  = (state == DEC_ISSUE) && !wide_sent;
  assign burst.valid = (state == DEC_ISSUE) && !desc_sent;
  assign wide_done   = wide_sent || wide_ready;
  assign desc_done   = desc_sent || burst.ready;

  assign burst.first_lane = first_lane;
  assign burst.len        = narrow_len;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= DEC_IDLE;
      ax_ready  <= 1'b0;
      wide_sent <= 1'b0;
      desc_sent <= 1'b0;
    end else begin
      case (state)
        DEC_IDLE: begin
          if (ax_fire) begin
            ax_ready  <= 1'b0;
            wide_sent <= 1'b0;
            desc_sent <= 1'b0;
            state     <= DEC_ISSUE;
          end else begin
            ax_ready <= 1'b1;
          end
        end
        DEC_ISSUE: begin
          wide_sent <= wide_done;
          desc_sent <= desc_done;
          if (wide_done && desc_done) begin
            ax_ready <= 1'b1;
            state    <= DEC_IDLE;
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

  // Request payload with the address forwarded as is
  always_ff @(posedge clk) begin
    if (ax_fire) begin
      wide_id    <= ax_id;
      wide_addr  <= ax_addr;
      wide_len   <= wide_len_full[LEN_WIDTH-1:0];
      first_lane <= ax_lane;
      narrow_len <= ax_len;
    end
  end

  // Wide length fits the len field and reaches the wide beat of the last narrow word
  a_wide_len_range: assert property (@(posedge clk) disable iff (!arst_n)
    ax_fire |-> !wide_len_full[LEN_WIDTH]
                && (wide_len_full[LEN_WIDTH-1:0]
                    == LEN_WIDTH'(((ax_addr + (ADDR_WIDTH'(ax_len) << LANE_LSB))
                                   >> (LANE_LSB + LANE_WIDTH))
                                  - (ax_addr >> (LANE_LSB + LANE_WIDTH)))));

endmodule

// File: source/dwc_burst_if.sv
`timescale 1ns/100ps

interface dwc_burst_if;
  import dwc_pkg::*;

  logic                  valid;
  logic                  ready;
  // Lane of the first narrow beat inside the first wide beat
  logic [LANE_WIDTH-1:0] first_lane;
  // Narrow burst length, beats minus one
  logic [LEN_WIDTH-1:0]  len;

  modport producer (
    output valid,
    output first_lane,
    output len,
    input  ready
  );

  modport consumer (
    input  valid,
    input  first_lane,
    input  len,
    output ready
  );

endinterface

// File: source/dwc_pkg.sv
package dwc_pkg;

  // Bus widths
  localparam int ADDR_WIDTH        = 32;
  localparam int ID_WIDTH          = 4;
  localparam int NARROW_DATA_WIDTH = 32;
  localparam int WIDE_DATA_WIDTH   = 256;
  localparam int NARROW_STRB_WIDTH = NARROW_DATA_WIDTH / 8;
  localparam int WIDE_STRB_WIDTH   = WIDE_DATA_WIDTH / 8;
  localparam int LEN_WIDTH         = 8;
  localparam int RESP_WIDTH        = 2;

  // Narrow lanes inside one wide beat
  localparam int LANE_COUNT = WIDE_DATA_WIDTH / NARROW_DATA_WIDTH;
  localparam int LANE_WIDTH = $clog2(LANE_COUNT);
  // Lowest address bit of the lane index, above the narrow byte offset
  localparam int LANE_LSB   = $clog2(NARROW_STRB_WIDTH);

  typedef enum logic {
    DEC_IDLE,
    DEC_ISSUE
  } decoder_state_e;

  typedef enum logic {
    UNPACK_EMPTY,
    UNPACK_DRAIN
  } unpack_state_e;

endpackage
